// ==== cachePkg.sv ====
package cachePkg;

    ////////////////////////////////
    // Geometry
    ////////////////////////////////
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 22;
    localparam int NUM_SETS = 256;
    localparam int NUM_WAYS = 4;

    typedef logic [1:0] wayIdx_t;

    // Lexicographic index of one of the 24 orderings, oldest way first
    typedef logic [4:0] lruCode_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        REFILL
    } ctrlState_t;

    typedef union packed {
        logic [ADDR_W-1:0] word;
        struct packed {
            logic [TAG_W-1:0]                  tag;
            logic [INDEX_W-1:0]                index;
            logic [ADDR_W-TAG_W-INDEX_W-1:0]   offset;
        } field;
    } cacheAddr_u;

    // Move one way to the newest position, others keep their order
    function automatic lruCode_t lruTouch(lruCode_t code, wayIdx_t way);
        wayIdx_t              oldOrder [NUM_WAYS];
        wayIdx_t              newOrder [NUM_WAYS];
        logic [NUM_WAYS-1:0]  used;
        int                   digit [NUM_WAYS];
        int                   rank;
        int                   n;
        int                   result;

        digit[0] = int'(code) / 6;
        digit[1] = (int'(code) % 6) / 2;
        digit[2] = int'(code) % 2;
        digit[3] = 0;

        // Decode: each digit picks among the ways not yet placed
        used = '0;
        for (int k = 0; k < NUM_WAYS; k++) begin
            rank = digit[k];
            oldOrder[k] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!used[w]) begin
                    if (rank == 0) begin
                        oldOrder[k] = wayIdx_t'(w);
                    end
                    rank = rank - 1;
                end
            end
            used[oldOrder[k]] = 1'b1;
        end

        n = 0;
        for (int k = 0; k < NUM_WAYS; k++) begin
            if (oldOrder[k] != way) begin
                newOrder[n] = oldOrder[k];
                n = n + 1;
            end
        end
        newOrder[NUM_WAYS-1] = way;

        // Encode back, mixed radix 4-3-2
        used = '0;
        result = 0;
        for (int k = 0; k < NUM_WAYS - 1; k++) begin
            rank = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (w < int'(newOrder[k]) && !used[w]) begin
                    rank = rank + 1;
                end
            end
            result = result * (NUM_WAYS - k) + rank;
            used[newOrder[k]] = 1'b1;
        end
        return lruCode_t'(result);
    endfunction

endpackage

// ==== cacheStore.sv ====
`timescale 1ns/1ns

module cacheStore import cachePkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  cacheAddr_u        address,
    input  wayIdx_t           victimWay,
    input  logic              wrEn,
    input  wayIdx_t           wrWay,
    input  logic [DATA_W-1:0] wrData,
    input  logic              wrDirty,
    output logic              hit,
    output wayIdx_t           hitWay,
    output logic [DATA_W-1:0] hitData,
    output logic              victimDirty,
    output logic [TAG_W-1:0]  victimTag,
    output logic [DATA_W-1:0] victimData
);

    logic [NUM_WAYS-1:0] validBits [NUM_SETS];
    logic [NUM_WAYS-1:0] dirtyBits [NUM_SETS];
    logic [TAG_W-1:0]    tagMem    [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0]   dataMem   [NUM_SETS][NUM_WAYS];

    logic [INDEX_W-1:0]  setIdx;
    logic [NUM_WAYS-1:0] hitVec;

    assign setIdx = address.field.index;

    ////////////////////////////////
    // Lookup
    ////////////////////////////////
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hitVec[w] = validBits[setIdx][w] &&
                        (tagMem[setIdx][w] == address.field.tag);
        end
    end

    // At most one way matches
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hitVec[w]) begin
                hitWay = wayIdx_t'(w);
            end
        end
    end

    assign hit     = |hitVec;
    assign hitData = dataMem[setIdx][hitWay];

    assign victimDirty = dirtyBits[setIdx][victimWay];
    assign victimTag   = tagMem[setIdx][victimWay];
    assign victimData  = dataMem[setIdx][victimWay];

    ////////////////////////////////
    // Write port
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                validBits[s] <= '0;
                dirtyBits[s] <= '0;
            end
        end else if (wrEn) begin
            validBits[setIdx][wrWay] <= 1'b1;
            dirtyBits[setIdx][wrWay] <= wrDirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[setIdx][wrWay]  <= address.field.tag;
            dataMem[setIdx][wrWay] <= wrData;
        end
    end

endmodule

// ==== lruTable.sv ====
`timescale 1ns/1ns

module lruTable import cachePkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  cacheAddr_u address,
    input  logic       touchEn,
    input  wayIdx_t    touchWay,
    output wayIdx_t    victimWay
);

    lruCode_t           codes [NUM_SETS];
    lruCode_t           curCode;
    lruCode_t           nextCode;
    logic [INDEX_W-1:0] setIdx;

    assign setIdx  = address.field.index;
    assign curCode = codes[setIdx];

    ////////////////////////////////
    // Victim decode
    ////////////////////////////////
    // Oldest way leads the ordering, six codes per leading way
    always_comb begin
        if (curCode < 5'd6) begin
            victimWay = 2'd0;
        end else if (curCode < 5'd12) begin
            victimWay = 2'd1;
        end else if (curCode < 5'd18) begin
            victimWay = 2'd2;
        end else begin
            victimWay = 2'd3;
        end
    end

    ////////////////////////////////
    // Move to newest
    ////////////////////////////////
    always_comb begin
        nextCode = lruTouch(curCode, touchWay);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                codes[s] <= '0;
            end
        end else if (touchEn) begin
            codes[setIdx] <= nextCode;
        end
    end

endmodule

// ==== cacheCtrl.sv ====
`timescale 1ns/1ns

module cacheCtrl import cachePkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cacheRead,
    input  logic              cacheWrite,
    input  cacheAddr_u        address,
    input  logic [DATA_W-1:0] writeData,
    input  logic              hit,
    input  wayIdx_t           hitWay,
    input  logic [DATA_W-1:0] hitData,
    input  wayIdx_t           victimWay,
    input  logic              victimDirty,
    input  logic [TAG_W-1:0]  victimTag,
    input  logic [DATA_W-1:0] victimData,
    input  logic              memReady,
    input  logic [DATA_W-1:0] memReadData,
    output logic              stall,
    output logic [DATA_W-1:0] readData,
    output logic              wrEn,
    output wayIdx_t           wrWay,
    output logic [DATA_W-1:0] wrData,
    output logic              wrDirty,
    output logic              touchEn,
    output wayIdx_t           touchWay,
    output logic              memRead,
    output logic              memWrite,
    output logic [ADDR_W-1:0] memAddress,
    output logic [DATA_W-1:0] memWriteData
);

    ctrlState_t state;
    logic       request;

    assign request = cacheRead || cacheWrite;
    assign stall   = (state != IDLE) || (request && !hit);

    // Victim line is frozen while the write-back is held
    assign memAddress   = (state == WRITE_BACK) ?
                          {victimTag, address.field.index, 2'b00} :
                          {address.field.tag, address.field.index, 2'b00};
    assign memWriteData = victimData;

    ////////////////////////////////
    // Store and LRU controls
    ////////////////////////////////
    always_comb begin
        wrEn     = 1'b0;
        wrWay    = hitWay;
        wrData   = writeData;
        wrDirty  = 1'b1;
        touchEn  = 1'b0;
        touchWay = hitWay;
        case (state)
            IDLE: begin
                if (request && hit) begin
                    touchEn = 1'b1;
                    wrEn    = cacheWrite;
                end
            end
            REFILL: begin
                wrWay    = victimWay;
                touchWay = victimWay;
                if (cacheWrite) begin
                    wrEn    = 1'b1;
                    touchEn = 1'b1;
                end else if (memRead && memReady) begin
                    // Refilled line arrives clean
                    wrEn    = 1'b1;
                    wrData  = memReadData;
                    wrDirty = 1'b0;
                    touchEn = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////
    // Miss FSM
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (request && !hit) begin
                        if (victimDirty) begin
                            state    <= WRITE_BACK;
                            memWrite <= 1'b1;
                        end else begin
                            state   <= REFILL;
                            memRead <= cacheRead;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (memReady) begin
                        state    <= REFILL;
                        memWrite <= 1'b0;
                        memRead  <= cacheRead;
                    end
                end
                REFILL: begin
                    if (cacheWrite) begin
                        state <= IDLE;
                    end else if (memReady) begin
                        state   <= IDLE;
                        memRead <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cacheRead && hit) begin
            readData <= hitData;
        end
    end

endmodule

// ==== cacheTop.sv ====
`timescale 1ns/1ns

module cacheTop import cachePkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cacheRead,
    input  logic              cacheWrite,
    input  cacheAddr_u        address,
    input  logic [DATA_W-1:0] writeData,
    input  logic              memReady,
    input  logic [DATA_W-1:0] memReadData,
    output logic              stall,
    output logic [DATA_W-1:0] readData,
    output logic              memRead,
    output logic              memWrite,
    output logic [ADDR_W-1:0] memAddress,
    output logic [DATA_W-1:0] memWriteData
);

    logic              hit;
    wayIdx_t           hitWay;
    logic [DATA_W-1:0] hitData;
    wayIdx_t           victimWay;
    logic              victimDirty;
    logic [TAG_W-1:0]  victimTag;
    logic [DATA_W-1:0] victimData;
    logic              wrEn;
    wayIdx_t           wrWay;
    logic [DATA_W-1:0] wrData;
    logic              wrDirty;
    logic              touchEn;
    wayIdx_t           touchWay;

    cacheStore u_store (
        .clk         (clk),
        .rstn        (rstn),
        .address     (address),
        .victimWay   (victimWay),
        .wrEn        (wrEn),
        .wrWay       (wrWay),
        .wrData      (wrData),
        .wrDirty     (wrDirty),
        .hit         (hit),
        .hitWay      (hitWay),
        .hitData     (hitData),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .victimData  (victimData)
    );

    lruTable u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .address   (address),
        .touchEn   (touchEn),
        .touchWay  (touchWay),
        .victimWay (victimWay)
    );

    cacheCtrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .cacheRead    (cacheRead),
        .cacheWrite   (cacheWrite),
        .address      (address),
        .writeData    (writeData),
        .hit          (hit),
        .hitWay       (hitWay),
        .hitData      (hitData),
        .victimWay    (victimWay),
        .victimDirty  (victimDirty),
        .victimTag    (victimTag),
        .victimData   (victimData),
        .memReady     (memReady),
        .memReadData  (memReadData),
        .stall        (stall),
        .readData     (readData),
        .wrEn         (wrEn),
        .wrWay        (wrWay),
        .wrData       (wrData),
        .wrDirty      (wrDirty),
        .touchEn      (touchEn),
        .touchWay     (touchWay),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddress   (memAddress),
        .memWriteData (memWriteData)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Released just after the third rising edge
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// ==== tbMemory.sv ====
`timescale 1ns/1ns

module tbMemory import cachePkg::*; (
    input  logic              clk,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic [ADDR_W-1:0] memAddress,
    input  logic [DATA_W-1:0] memWriteData,
    output logic              memReady,
    output logic [DATA_W-1:0] memReadData
);

    logic [DATA_W-1:0] words [logic [ADDR_W-1:0]];
    logic [31:0]       randState;
    logic              busy;
    int                waitLeft;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One memReady pulse per request, 1 to 8 cycles after it rose
    initial begin
        memReady    = 1'b0;
        memReadData = '0;
        randState   = 32'h4f1a_d1d6;
        busy        = 1'b0;
        waitLeft    = 0;
        forever begin
            @(posedge clk);
            #1;
            if (memReady) begin
                memReady = 1'b0;
                busy     = 1'b0;
            end else if (memRead || memWrite) begin
                if (!busy) begin
                    randState = xorshift(randState);
                    waitLeft  = int'(randState[2:0]);
                    busy      = 1'b1;
                end else begin
                    waitLeft = waitLeft - 1;
                end
                if (waitLeft == 0) begin
                    memReady = 1'b1;
                    if (memWrite) begin
                        words[memAddress] = memWriteData;
                    end else if (words.exists(memAddress)) begin
                        memReadData = words[memAddress];
                    end else begin
                        memReadData = xorshift(memAddress);
                    end
                end
            end
        end
    end

endmodule

// ==== cacheTb.sv ====
`timescale 1ns/1ns

module cacheTb import cachePkg::*; ();

    localparam int STALL_LIMIT = 200;
    localparam int RANDOM_OPS  = 400;

    logic              clk;
    logic              rstn;
    logic              cacheRead;
    logic              cacheWrite;
    cacheAddr_u        address;
    logic [DATA_W-1:0] writeData;
    logic              memReady;
    logic [DATA_W-1:0] memReadData;
    logic              stall;
    logic [DATA_W-1:0] readData;
    logic              memRead;
    logic              memWrite;
    logic [ADDR_W-1:0] memAddress;
    logic [DATA_W-1:0] memWriteData;

    // Reference model state
    logic [TAG_W-1:0]  modelTag   [NUM_SETS][NUM_WAYS];
    logic              modelValid [NUM_SETS][NUM_WAYS];
    logic              modelDirty [NUM_SETS][NUM_WAYS];
    int                lastUse    [NUM_SETS][NUM_WAYS];
    int                useStamp;
    logic [DATA_W-1:0] archWords  [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] memShadow  [logic [ADDR_W-1:0]];

    logic              expIsWrite [$];
    cacheAddr_u        expAddr    [$];
    logic [DATA_W-1:0] expData    [$];
    logic [DATA_W-1:0] expRead    [$];
    cacheAddr_u        lastWbAddr;
    logic [DATA_W-1:0] lastWbData;
    logic [31:0]       randState;

    tbClock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    tbMemory u_mem (
        .clk          (clk),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memReady     (memReady),
        .memReadData  (memReadData)
    );

    cacheTop u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .cacheRead    (cacheRead),
        .cacheWrite   (cacheWrite),
        .address      (address),
        .writeData    (writeData),
        .memReady     (memReady),
        .memReadData  (memReadData),
        .stall        (stall),
        .readData     (readData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddress   (memAddress),
        .memWriteData (memWriteData)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        randState = xorshift(randState);
        return randState;
    endfunction

    function automatic cacheAddr_u makeAddr(input logic [TAG_W-1:0] tag,
                                            input logic [INDEX_W-1:0] index);
        cacheAddr_u a;
        a.field.tag    = tag;
        a.field.index  = index;
        a.field.offset = '0;
        return a;
    endfunction

    // Untouched words hold the memory's fill pattern
    function automatic logic [DATA_W-1:0] archValue(input logic [ADDR_W-1:0] a);
        return archWords.exists(a) ? archWords[a] : xorshift(a);
    endfunction

    function automatic logic [DATA_W-1:0] memValue(input logic [ADDR_W-1:0] a);
        return memShadow.exists(a) ? memShadow[a] : xorshift(a);
    endfunction

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    // Queues the memory traffic of one access, returns the word a read must see
    function automatic logic [DATA_W-1:0] predictAccess(input logic              isWrite,
                                                        input cacheAddr_u        addr,
                                                        input logic [DATA_W-1:0] wdata);
        logic [INDEX_W-1:0] s;
        cacheAddr_u         lineAddr;
        cacheAddr_u         victimAddr;
        wayIdx_t            way;
        logic               found;
        logic [DATA_W-1:0]  readWord;

        s        = addr.field.index;
        lineAddr = makeAddr(addr.field.tag, s);
        found    = 1'b0;
        way      = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (modelValid[s][w] && modelTag[s][w] == addr.field.tag) begin
                found = 1'b1;
                way   = wayIdx_t'(w);
            end
        end
        if (!found) begin
            // Least recently used way goes, valid or not
            for (int w = 1; w < NUM_WAYS; w++) begin
                if (lastUse[s][w] < lastUse[s][way]) begin
                    way = wayIdx_t'(w);
                end
            end
            if (modelDirty[s][way]) begin
                victimAddr = makeAddr(modelTag[s][way], s);
                memShadow[victimAddr.word] = archValue(victimAddr.word);
                expIsWrite.push_back(1'b1);
                expAddr.push_back(victimAddr);
                expData.push_back(memShadow[victimAddr.word]);
            end
            if (!isWrite) begin
                expIsWrite.push_back(1'b0);
                expAddr.push_back(lineAddr);
            end
            modelValid[s][way] = 1'b1;
            modelDirty[s][way] = 1'b0;
            modelTag[s][way]   = addr.field.tag;
        end
        useStamp           = useStamp + 1;
        lastUse[s][way]    = useStamp;
        if (isWrite) begin
            modelDirty[s][way]         = 1'b1;
            archWords[lineAddr.word]   = wdata;
        end
        readWord = archValue(lineAddr.word);
        if (!found && !isWrite) begin
            // A refilled word comes straight from memory
            readWord = memValue(lineAddr.word);
        end
        return readWord;
    endfunction

    task automatic stopOnError();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        stopOnError();
    endtask

    task automatic checkWord(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, expected %h, got %h", $time, what, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkAddr(input cacheAddr_u actual, input cacheAddr_u expected,
                             input string what);
        if (actual.word !== expected.word) begin
            $display("mismatch at %0t: %s, expected %h, got %h", $time, what,
                     expected.word, actual.word);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, expected %b, got %b", $time, what, expected, actual);
            stopOnError();
        end
    endtask

    // Called just after a rising edge, returns just after the completing edge
    task automatic runAccess(input logic isWrite, input cacheAddr_u addr,
                             input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] expected;
        int                cycles;
        expected = predictAccess(isWrite, addr, wdata);
        if (!isWrite) begin
            expRead.push_back(expected);
        end
        cacheRead  = !isWrite;
        cacheWrite = isWrite;
        address    = addr;
        writeData  = wdata;
        cycles     = 0;
        @(negedge clk);
        while (stall) begin
            cycles = cycles + 1;
            if (cycles > STALL_LIMIT) begin
                reportTimeout("stall to fall");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cacheRead  = 1'b0;
        cacheWrite = 1'b0;
    endtask

    ////////////////////////////////
    // Compare process
    ////////////////////////////////
    initial begin
        logic              pendingRead;
        logic              held;
        logic              heldWrite;
        cacheAddr_u        heldAddr;
        logic [DATA_W-1:0] heldData;
        pendingRead = 1'b0;
        held        = 1'b0;
        heldWrite   = 1'b0;
        heldAddr    = '0;
        heldData    = '0;
        forever begin
            @(negedge clk);
            if (pendingRead) begin
                checkWord(readData, expRead.pop_front(), "read data");
                pendingRead = 1'b0;
            end
            if (rstn && (cacheRead || cacheWrite) && !stall) begin
                checkFlag(expAddr.size() == 0, 1'b1, "memory traffic done before completion");
                pendingRead = cacheRead;
            end
            if (held) begin
                checkFlag(memRead || memWrite, 1'b1, "request held until memReady");
                checkFlag(memWrite, heldWrite, "request kind held");
                checkAddr(memAddress, heldAddr, "memAddress held");
                if (heldWrite) begin
                    checkWord(memWriteData, heldData, "memWriteData held");
                end
            end
            held = 1'b0;
            if (rstn && (memRead || memWrite)) begin
                if (!memReady) begin
                    held      = 1'b1;
                    heldWrite = memWrite;
                    heldAddr  = memAddress;
                    heldData  = memWriteData;
                end else begin
                    if (expAddr.size() == 0) begin
                        $display("Unexpected memory transaction to address %h", memAddress);
                        stopOnError();
                    end
                    checkFlag(memWrite, expIsWrite.pop_front(), "memory transaction kind");
                    checkAddr(memAddress, expAddr.pop_front(), "memory transaction address");
                    if (memWrite) begin
                        checkWord(memWriteData, expData.pop_front(), "write-back data");
                        lastWbAddr = memAddress;
                        lastWbData = memWriteData;
                    end
                end
            end
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////
    initial begin
        cacheAddr_u        a;
        logic [31:0]       r;
        logic [TAG_W-1:0]  tagBase;
        int                waitCycles;
        cacheRead  = 1'b0;
        cacheWrite = 1'b0;
        address    = '0;
        writeData  = '0;
        lastWbAddr = '0;
        lastWbData = '0;
        randState  = 32'h4f1a_d1d6;
        tagBase    = 22'h2a0;
        // Code 0 after reset, way 0 oldest
        useStamp   = NUM_WAYS;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                modelValid[s][w] = 1'b0;
                modelDirty[s][w] = 1'b0;
                modelTag[s][w]   = '0;
                lastUse[s][w]    = w;
            end
        end

        waitCycles = 0;
        while (!rstn) begin
            @(posedge clk);
            waitCycles = waitCycles + 1;
            if (waitCycles > 20) begin
                reportTimeout("reset release");
            end
        end
        @(negedge clk);
        checkFlag(stall, 1'b0, "stall after reset");
        checkFlag(memRead, 1'b0, "memRead after reset");
        checkFlag(memWrite, 1'b0, "memWrite after reset");
        @(posedge clk);
        #1;

        // Cold read, read hit, write hit, read back
        a = makeAddr(22'h0a5, 8'h10);
        runAccess(1'b0, a, '0);
        runAccess(1'b0, a, '0);
        runAccess(1'b1, a, 32'hcafe_0001);
        runAccess(1'b0, a, '0);

        // Fill one set, touch in order 2 0 3 1, then a fifth tag evicts tag 2
        for (int k = 0; k < NUM_WAYS; k++) begin
            runAccess(1'b1, makeAddr(tagBase + TAG_W'(k), 8'h22), 32'h5eed_0000 + k);
        end
        runAccess(1'b0, makeAddr(tagBase + 22'd2, 8'h22), '0);
        runAccess(1'b0, makeAddr(tagBase + 22'd0, 8'h22), '0);
        runAccess(1'b0, makeAddr(tagBase + 22'd3, 8'h22), '0);
        runAccess(1'b0, makeAddr(tagBase + 22'd1, 8'h22), '0);
        runAccess(1'b0, makeAddr(tagBase + 22'd4, 8'h22), '0);
        checkAddr(lastWbAddr, makeAddr(tagBase + 22'd2, 8'h22), "LRU victim address");
        checkWord(lastWbData, 32'h5eed_0002, "LRU victim data");

        // Eight tags over four sets, random offsets
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = nextRandom();
            a = makeAddr(22'h3c0 + {19'd0, r[2:0]}, 8'h40 + {6'd0, r[4:3]});
            a.field.offset = r[6:5];
            runAccess(r[7], a, nextRandom());
        end

        waitCycles = 0;
        while (expRead.size() != 0) begin
            @(negedge clk);
            waitCycles = waitCycles + 1;
            if (waitCycles > 10) begin
                reportTimeout("the last read check");
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
cachePkg.sv
cacheStore.sv
lruTable.sv
cacheCtrl.sv
cacheTop.sv
tbClock.sv
tbMemory.sv
cacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cacheTb -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/VcacheTb > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
